// ==== flist.f ====
+incdir+common
common/csr_pkg.sv
csr/csr_decode.sv
csr/csr_regs.sv
csr/csr_result.sv
csr/csr_unit.sv
sim/csr_unit_asserts.sv
sim/csr_unit_tb.sv

// ==== Makefile ====
# Verilator build and run of the CSR file testbench

VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/csr_unit_tb.sv ====
// Testbench for the machine-mode CSR file with a register model and response checks
`timescale 1ns/10ps
`default_nettype none

`include "csr_config.svh"

module csr_unit_tb
   import csr_pkg::*;
;

   localparam int N_RAND  = 40;
   localparam int N_TRAP  = 4;
   // Rough cycle budget of all tests together
   localparam int TOTAL_CYCLES = 3 + 60 + N_RAND * 6 + 40 + N_TRAP * 30 + 160 + 120;

   logic       clk_in;
   logic       rst;
   csr_req_t   req;
   trap_req_t  trap;
   logic       mret;
   logic       retire;
   logic       irq_sw;
   logic       irq_timer;
   logic       irq_ext;
   csr_rsp_t   rsp;
   xlen_t      trap_pc;
   xlen_t      epc;
   logic       irq_pending;

   // Register model
   xlen_t m_mstatus, m_mie, m_mtvec, m_minhibit, m_mscratch;
   xlen_t m_mepc, m_mcause, m_mtval, m_mip;

   // Expected responses in request order
   logic  exp_chk_q[$];
   logic  exp_ill_q[$];
   xlen_t exp_data_q[$];
   // Unchecked read data for counter tests
   xlen_t got_q[$];

   string       cur_test;
   int          checks;
   int          errors;
   int          test_err;
   logic [31:0] rng_state;

   csr_unit i_csr_unit
   (
      .clk_in (clk_in), .rst (rst), .req (req), .trap (trap), .mret (mret),
      .retire (retire), .irq_sw (irq_sw), .irq_timer (irq_timer), .irq_ext (irq_ext),
      .rsp (rsp), .trap_pc (trap_pc), .epc (epc), .irq_pending (irq_pending)
   );

   bind csr_unit csr_unit_asserts i_csr_unit_asserts
   (
      .clk_in (clk_in), .rst (rst), .req (req), .rsp (rsp),
      .trap_pc (trap_pc), .irq_pending (irq_pending)
   );

   // xorshift32 generator
   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   // ----------------------------------------
   // Reference model returning {check, illegal, rdata}
   // ----------------------------------------
   function automatic logic [33:0] ref_access(csr_op_e op, csr_addr_t addr, xlen_t wd);
      xlen_t rd;
      xlen_t cur;
      xlen_t mask;
      xlen_t nv;
      logic  known;
      logic  cnt;
      logic  wable;
      logic  ro;
      logic  ww;
      logic  ill;
      known = 1'b1;
      cur   = '0;
      case (addr)
         `CSR_ADDR_MSTATUS:       cur = m_mstatus;
         `CSR_ADDR_MIE:           cur = m_mie;
         `CSR_ADDR_MTVEC:         cur = m_mtvec;
         `CSR_ADDR_MCOUNTINHIBIT: cur = m_minhibit;
         `CSR_ADDR_MSCRATCH:      cur = m_mscratch;
         `CSR_ADDR_MEPC:          cur = m_mepc;
         `CSR_ADDR_MCAUSE:        cur = m_mcause;
         `CSR_ADDR_MTVAL:         cur = m_mtval;
         `CSR_ADDR_MIP:           cur = m_mip;
         `CSR_ADDR_MISA:          cur = `CSR_MISA_VALUE;
         `CSR_ADDR_MVENDORID:     cur = `CSR_MVENDORID_VALUE;
         `CSR_ADDR_MARCHID:       cur = `CSR_MARCHID_VALUE;
         `CSR_ADDR_MIMPID:        cur = `CSR_MIMPID_VALUE;
         `CSR_ADDR_MHARTID:       cur = `CSR_MHARTID_VALUE;
         `CSR_ADDR_MCYCLE, `CSR_ADDR_MCYCLEH, `CSR_ADDR_MINSTRET, `CSR_ADDR_MINSTRETH:
            cur = '0;
         default:                 known = 1'b0;
      endcase
      // Writable bits of the masked registers
      case (addr)
         `CSR_ADDR_MSTATUS:       mask = `CSR_MASK_MSTATUS;
         `CSR_ADDR_MIE:           mask = `CSR_MASK_MIE;
         `CSR_ADDR_MTVEC:         mask = `CSR_MASK_MTVEC;
         `CSR_ADDR_MCOUNTINHIBIT: mask = 32'h5;
         default:                 mask = 32'hFFFF_FFFF;
      endcase
      // Counters move on their own and are checked by the counter test
      cnt   = addr inside {`CSR_ADDR_MCYCLE, `CSR_ADDR_MCYCLEH, `CSR_ADDR_MINSTRET,
                           `CSR_ADDR_MINSTRETH};
      wable = !cnt && !(addr inside {`CSR_ADDR_MIP, `CSR_ADDR_MISA});
      rd  = (addr == `CSR_ADDR_MSTATUS) ? (cur | `CSR_MSTATUS_MPP) : cur;
      ro  = &addr[11:10];
      ww  = (op == CSR_RW) || (wd != '0);
      ill = !known || (ro && ww);
      if (!ill && ww && wable && !ro)
      begin
         nv = (op == CSR_RW) ? wd : (op == CSR_RS) ? (cur | wd) : (cur & ~wd);
         nv = (cur & ~mask) | (nv & mask);
         case (addr)
            `CSR_ADDR_MSTATUS:       m_mstatus  = nv;
            `CSR_ADDR_MIE:           m_mie      = nv;
            `CSR_ADDR_MTVEC:         m_mtvec    = nv;
            `CSR_ADDR_MCOUNTINHIBIT: m_minhibit = nv;
            `CSR_ADDR_MSCRATCH:      m_mscratch = nv;
            `CSR_ADDR_MEPC:          m_mepc     = nv;
            `CSR_ADDR_MCAUSE:        m_mcause   = nv;
            `CSR_ADDR_MTVAL:         m_mtval    = nv;
            default:                 nv = nv;
         endcase
      end
      return {!cnt, ill, ill ? 32'h0 : rd};
   endfunction

   // Plain value check outside the response stream
   task automatic check_equal(string what, xlen_t exp, xlen_t act);
      checks++;
      if (exp !== act)
      begin
         errors++;
         $display("MISMATCH %s %s expected %h actual %h", cur_test, what, exp, act);
      end
   endtask

   // ----------------------------------------
   // Stimulus helpers
   // ----------------------------------------
   task automatic issue(csr_op_e op, csr_addr_t addr, xlen_t wd);
      logic [33:0] e;
      e = ref_access(op, addr, wd);
      exp_chk_q.push_back(e[33]);
      exp_ill_q.push_back(e[32]);
      exp_data_q.push_back(e[31:0]);
      @(posedge clk_in);
      req       <= '{valid: 1'b1, op: op, addr: addr, wdata: wd};
      retire    <= 1'b0;
      trap.take <= 1'b0;
      mret      <= 1'b0;
   endtask

   task automatic idle();
      @(posedge clk_in);
      req.valid <= 1'b0;
      retire    <= 1'b0;
      trap.take <= 1'b0;
      mret      <= 1'b0;
   endtask

   // Bounded wait until every request has its response
   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_data_q.size() != 0 && n < 10)
      begin
         @(negedge clk_in);
         n++;
      end
      if (exp_data_q.size() != 0)
      begin
         errors++;
         $display("%s: responses did not arrive", cur_test);
      end
   endtask

   task automatic start_test(string name);
      cur_test = name;
      test_err = errors;
   endtask

   task automatic end_test();
      idle();
      wait_drain();
      $display("test %s finished, %0d errors", cur_test, errors - test_err);
   endtask

   // Trap entry in the model and on the DUT pins
   task automatic take_trap(cause_t c, xlen_t e, xlen_t t);
      xlen_t exp_pc;
      m_mepc       = e;
      m_mcause     = c;
      m_mtval      = t;
      m_mstatus[7] = m_mstatus[3];
      m_mstatus[3] = 1'b0;
      @(posedge clk_in);
      req.valid <= 1'b0;
      trap      <= '{take: 1'b1, cause: c, epc: e, tval: t};
      idle();
      @(negedge clk_in);
      exp_pc = m_mtvec & ~32'h3;
      // Vectored mode adds four times the interrupt code
      if (m_mtvec[1:0] == 2'b01 && c[31])
         exp_pc = exp_pc + 4 * c[30:0];
      check_equal("trap_pc", exp_pc, trap_pc);
   endtask

   task automatic do_mret();
      m_mstatus[3] = m_mstatus[7];
      m_mstatus[7] = 1'b1;
      @(posedge clk_in);
      req.valid <= 1'b0;
      mret      <= 1'b1;
      idle();
      @(negedge clk_in);
      check_equal("epc", m_mepc, epc);
   endtask

   task automatic set_lines(logic [2:0] v, logic exp_pend);
      @(posedge clk_in);
      req.valid <= 1'b0;
      irq_sw    <= v[0];
      irq_timer <= v[1];
      irq_ext   <= v[2];
      m_mip     = {20'h0, v[2], 3'b0, v[1], 3'b0, v[0], 3'b0};
      // First read that can see the sampled lines
      issue(CSR_RS, `CSR_ADDR_MIP, '0);
      @(negedge clk_in);
      check_equal("irq_pending", xlen_t'(exp_pend), xlen_t'(irq_pending));
   endtask

   // Counter distance between two reads k cycles apart
   task automatic measure(csr_addr_t addr, int k, int pulses, xlen_t exp_diff);
      xlen_t a;
      xlen_t b;
      got_q.delete();
      issue(CSR_RS, addr, '0);
      repeat (pulses)
      begin
         @(posedge clk_in);
         req.valid <= 1'b0;
         retire    <= 1'b1;
      end
      repeat (k - 1 - pulses) idle();
      issue(CSR_RS, addr, '0);
      idle();
      wait_drain();
      a = got_q.pop_front();
      b = got_q.pop_front();
      check_equal("counter distance", exp_diff, b - a);
   endtask

   // ----------------------------------------
   // Compare process
   // ----------------------------------------
   always @(negedge clk_in)
   begin
      if (!rst && rsp.valid)
      begin
         if (exp_data_q.size() == 0)
         begin
            errors++;
            $display("%s: response without a pending request", cur_test);
         end
         else
         begin
            checks++;
            if (rsp.illegal !== exp_ill_q[0])
            begin
               errors++;
               $display("MISMATCH %s illegal expected %0b actual %0b",
                        cur_test, exp_ill_q[0], rsp.illegal);
            end
            if (exp_chk_q[0] && rsp.rdata !== exp_data_q[0])
            begin
               errors++;
               $display("MISMATCH %s rdata expected %h actual %h",
                        cur_test, exp_data_q[0], rsp.rdata);
            end
            if (!exp_chk_q[0])
               got_q.push_back(rsp.rdata);
            void'(exp_chk_q.pop_front());
            void'(exp_ill_q.pop_front());
            void'(exp_data_q.pop_front());
         end
      end
   end

   initial
   begin
      clk_in = 1'b0;
      forever #20 clk_in = ~clk_in;
   end

   // Watchdog
   initial
   begin
      #(TOTAL_CYCLES * 40 + 4000);
      $display("Watchdog expired before the tests completed");
      $display("Something failed");
      $finish;
   end

   // ----------------------------------------
   // Test sequence
   // ----------------------------------------
   initial
   begin
      csr_addr_t all_addr[18];
      xlen_t     r;
      all_addr = '{`CSR_ADDR_MSTATUS, `CSR_ADDR_MISA, `CSR_ADDR_MIE, `CSR_ADDR_MTVEC,
                   `CSR_ADDR_MCOUNTINHIBIT, `CSR_ADDR_MSCRATCH, `CSR_ADDR_MEPC,
                   `CSR_ADDR_MCAUSE, `CSR_ADDR_MTVAL, `CSR_ADDR_MIP, `CSR_ADDR_MCYCLE,
                   `CSR_ADDR_MCYCLEH, `CSR_ADDR_MINSTRET, `CSR_ADDR_MINSTRETH,
                   `CSR_ADDR_MVENDORID, `CSR_ADDR_MARCHID, `CSR_ADDR_MIMPID,
                   `CSR_ADDR_MHARTID};
      rng_state = 32'd27;
      checks = 0;
      errors = 0;
      cur_test = "reset";
      rst = 1'b1;
      req = '0;
      trap = '0;
      mret = 1'b0;
      retire = 1'b0;
      irq_sw = 1'b0;
      irq_timer = 1'b0;
      irq_ext = 1'b0;
      {m_mstatus, m_mie, m_minhibit, m_mscratch, m_mepc, m_mcause, m_mtval, m_mip} = '0;
      m_mtvec = `CSR_RESET_VECTOR;
      repeat (3) @(posedge clk_in);
      rst <= 1'b0;

      start_test("reset_values");
      foreach (all_addr[i])
         issue(CSR_RS, all_addr[i], '0);
      end_test();

      // Random ops on plain and masked registers with a read after each
      start_test("random_rw");
      for (int i = 0; i < N_RAND; i++)
      begin
         r = next_rand();
         case (r[1:0])
            2'd0:    all_addr[0] = `CSR_ADDR_MSCRATCH;
            2'd1:    all_addr[0] = `CSR_ADDR_MTVEC;
            2'd2:    all_addr[0] = `CSR_ADDR_MIE;
            default: all_addr[0] = `CSR_ADDR_MSTATUS;
         endcase
         issue(csr_op_e'(2'd1 + 2'(r[7:2] % 3)), all_addr[0], next_rand());
         issue(CSR_RS, all_addr[0], '0);
      end
      all_addr[0] = `CSR_ADDR_MSTATUS;
      end_test();

      start_test("illegal");
      issue(CSR_RS, 12'h7C0, '0);
      issue(CSR_RW, 12'h000, next_rand());
      issue(CSR_RC, 12'h3A0, 32'hFFFF_FFFF);
      issue(CSR_RW, `CSR_ADDR_MVENDORID, 32'h1234_5678);
      issue(CSR_RS, `CSR_ADDR_MHARTID, 32'h0000_0003);
      issue(CSR_RS, `CSR_ADDR_MVENDORID, '0);
      issue(CSR_RS, `CSR_ADDR_MHARTID, '0);
      end_test();

      start_test("trap_mret");
      for (int i = 0; i < N_TRAP; i++)
      begin
         r = next_rand();
         // Mode and interrupt bit walk through all four pairs
         issue(CSR_RW, `CSR_ADDR_MTVEC, {r[31:8], 7'h0, i[0]});
         issue(CSR_RW, `CSR_ADDR_MSTATUS, {24'h0, r[2], 3'b0, i[0] ^ i[1], 3'b0});
         idle();
         take_trap({i[1], 27'h0, r[7:5], 1'b1}, next_rand(), next_rand());
         issue(CSR_RS, `CSR_ADDR_MEPC, '0);
         issue(CSR_RS, `CSR_ADDR_MCAUSE, '0);
         issue(CSR_RS, `CSR_ADDR_MTVAL, '0);
         issue(CSR_RS, `CSR_ADDR_MSTATUS, '0);
         idle();
         do_mret();
         issue(CSR_RS, `CSR_ADDR_MSTATUS, '0);
      end
      end_test();

      start_test("counters");
      measure(`CSR_ADDR_MCYCLE, 7, 0, 32'd7);
      measure(`CSR_ADDR_MINSTRET, 9, 5, 32'd5);
      issue(CSR_RW, `CSR_ADDR_MCOUNTINHIBIT, 32'h5);
      idle();
      measure(`CSR_ADDR_MCYCLE, 6, 0, 32'd0);
      measure(`CSR_ADDR_MINSTRET, 8, 4, 32'd0);
      issue(CSR_RW, `CSR_ADDR_MCOUNTINHIBIT, 32'h0);
      end_test();

      // Each line with its enable on and off and then with global MIE off
      start_test("interrupts");
      issue(CSR_RS, `CSR_ADDR_MSTATUS, 32'h8);
      for (int j = 0; j < 3; j++)
      begin
         for (int en = 0; en < 2; en++)
         begin
            issue(CSR_RW, `CSR_ADDR_MIE, en ? (32'h8 << (4 * j)) : 32'h0);
            set_lines(3'b001 << j, en == 1);
         end
      end
      issue(CSR_RC, `CSR_ADDR_MSTATUS, 32'h8);
      set_lines(3'b111, 1'b0);
      set_lines(3'b000, 1'b0);
      end_test();

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim/csr_unit_asserts.sv ====
// Concurrent checks on CSR response timing, trap vector alignment and reset state
`timescale 1ns/10ps
`default_nettype none

module csr_unit_asserts
   import csr_pkg::*;
(
   input wire logic     clk_in,
   input wire logic     rst,
   input wire csr_req_t req,
   input wire csr_rsp_t rsp,
   input wire xlen_t    trap_pc,
   input wire logic     irq_pending
);

   // ----------------------------------------
   // Response timing
   // ----------------------------------------
   // Every request answers on the next edge
   a_rsp_follows_req: assert property (@(posedge clk_in) disable iff (rst)
      req.valid |=> rsp.valid)
      else $error("response missing one cycle after a request");

   // No response without a request
   a_no_spurious_rsp: assert property (@(posedge clk_in) disable iff (rst)
      !req.valid |=> !rsp.valid)
      else $error("response without a request");

   // ----------------------------------------
   // Trap target
   // ----------------------------------------
   // Word aligned in direct and vectored mode
   a_trap_pc_aligned: assert property (@(posedge clk_in) disable iff (rst)
      trap_pc[1:0] == 2'b00)
      else $error("trap target not word aligned");

   // Reset clears response and interrupt pending
   a_reset_state: assert property (@(posedge clk_in)
      rst |=> (!rsp.valid && !irq_pending))
      else $error("outputs not cleared by reset");

endmodule

`default_nettype wire

// ==== csr/csr_unit.sv ====
// Machine-mode CSR file top level joining decode, storage and response
`timescale 1ns/10ps
`default_nettype none

module csr_unit
   import csr_pkg::*;
(
   input  logic      clk_in,
   input  logic      rst,
   input  csr_req_t  req,
   input  trap_req_t trap,
   input  logic      mret,
   input  logic      retire,
   input  logic      irq_sw,
   input  logic      irq_timer,
   input  logic      irq_ext,
   output csr_rsp_t  rsp,
   output xlen_t     trap_pc,
   output xlen_t     epc,
   output logic      irq_pending
);

   // Decoded access, shared by storage and response
   csr_sel_t   sel;
   // Current register contents
   csr_state_t state;

   // ----------------------------------------
   // Address decode, same cycle
   // ----------------------------------------
   csr_decode i_csr_decode
   (
      .req (req),
      .sel (sel)
   );

   // ----------------------------------------
   // Register update
   // ----------------------------------------
   csr_regs i_csr_regs
   (
      .clk_in      (clk_in),
      .rst         (rst),
      .sel         (sel),
      .trap        (trap),
      .mret        (mret),
      .retire      (retire),
      .irq_sw      (irq_sw),
      .irq_timer   (irq_timer),
      .irq_ext     (irq_ext),
      .state       (state),
      .trap_pc     (trap_pc),
      .epc         (epc),
      .irq_pending (irq_pending)
   );

   // Registered read response, old value before the write
   csr_result i_csr_result
   (
      .clk_in (clk_in),
      .rst    (rst),
      .sel    (sel),
      .state  (state),
      .rsp    (rsp)
   );

endmodule

`default_nettype wire

// ==== csr/csr_result.sv ====
// CSR read mux with the registered access response
`timescale 1ns/10ps
`default_nettype none

`include "csr_config.svh"

module csr_result
   import csr_pkg::*;
(
   input  logic       clk_in,
   input  logic       rst,
   input  csr_sel_t   sel,
   input  csr_state_t state,
   output csr_rsp_t   rsp
);

   xlen_t rdata_sel;
   xlen_t rdata_q;
   logic  valid_q;
   logic  illegal_q;

   // ----------------------------------------
   // Old value of the selected register
   // ----------------------------------------
   always_comb
   begin
      case (sel.reg_sel)
         // MPP always reads as machine mode
         REG_MSTATUS:       rdata_sel = state.mstatus | `CSR_MSTATUS_MPP;
         REG_MISA:          rdata_sel = `CSR_MISA_VALUE;
         REG_MIE:           rdata_sel = state.mie;
         REG_MTVEC:         rdata_sel = state.mtvec;
         REG_MCOUNTINHIBIT: rdata_sel = state.mcountinhibit;
         REG_MSCRATCH:      rdata_sel = state.mscratch;
         REG_MEPC:          rdata_sel = state.mepc;
         REG_MCAUSE:        rdata_sel = state.mcause;
         REG_MTVAL:         rdata_sel = state.mtval;
         REG_MIP:           rdata_sel = state.mip;
         REG_MCYCLE:        rdata_sel = state.mcycle_lo;
         REG_MCYCLEH:       rdata_sel = state.mcycle_hi;
         REG_MINSTRET:      rdata_sel = state.minstret_lo;
         REG_MINSTRETH:     rdata_sel = state.minstret_hi;
         REG_MVENDORID:     rdata_sel = `CSR_MVENDORID_VALUE;
         REG_MARCHID:       rdata_sel = `CSR_MARCHID_VALUE;
         REG_MIMPID:        rdata_sel = `CSR_MIMPID_VALUE;
         REG_MHARTID:       rdata_sel = `CSR_MHARTID_VALUE;
         default:           rdata_sel = '0;
      endcase
      // Illegal access returns zero
      if (sel.illegal)
         rdata_sel = '0;
   end

   // ----------------------------------------
   // Response register
   // ----------------------------------------
   always_ff @(posedge clk_in)
   begin
      if (rst)
      begin
         valid_q   <= 1'b0;
         illegal_q <= 1'b0;
      end
      else
      begin
         valid_q   <= sel.valid;
         illegal_q <= sel.illegal;
      end
   end

   always_ff @(posedge clk_in)
   begin
      rdata_q <= rdata_sel;
   end

   assign rsp = '{valid: valid_q, rdata: rdata_q, illegal: illegal_q};

endmodule

`default_nettype wire

// ==== csr/csr_regs.sv ====
// CSR storage with masked writes, trap entry, mret, counters and interrupt sampling
`timescale 1ns/10ps
`default_nettype none

`include "csr_config.svh"

module csr_regs
   import csr_pkg::*;
(
   input  logic       clk_in,
   input  logic       rst,
   input  csr_sel_t   sel,
   input  trap_req_t  trap,
   input  logic       mret,
   input  logic       retire,
   input  logic       irq_sw,
   input  logic       irq_timer,
   input  logic       irq_ext,
   output csr_state_t state,
   output xlen_t      trap_pc,
   output xlen_t      epc,
   output logic       irq_pending
);

   csr_state_t nxt;
   logic       wr;
   logic       cycle_inc;
   logic       instret_inc;
   counter_t   mcycle_nxt;
   counter_t   minstret_nxt;
   xlen_t      mtvec_base;
   xlen_t      vector_off;

   // Read-modify-write of one register, hard-wired bits keep their old value
   function automatic xlen_t apply_op(csr_op_e op, xlen_t old, xlen_t wd, xlen_t mask);
      xlen_t val;
      case (op)
         CSR_RW:  val = wd;
         CSR_RS:  val = old | wd;
         CSR_RC:  val = old & ~wd;
         default: val = old;
      endcase
      return (old & ~mask) | (val & mask);
   endfunction

   // A trap or mret in the same cycle wins over the CSR write
   assign wr = sel.write_en && !trap.take && !mret;

   // ----------------------------------------
   // Counters
   // ----------------------------------------
   assign cycle_inc    = !state.mcountinhibit[0];
   assign instret_inc  = retire && !state.mcountinhibit[2];
   assign mcycle_nxt   = {state.mcycle_hi, state.mcycle_lo} + counter_t'(cycle_inc);
   assign minstret_nxt = {state.minstret_hi, state.minstret_lo} + counter_t'(instret_inc);

   // ----------------------------------------
   // Next state
   // ----------------------------------------
   always_comb
   begin
      nxt = state;

      // Interrupt lines land in MSIP, MTIP, MEIP
      nxt.mip = '0;
      nxt.mip[3]  = irq_sw;
      nxt.mip[7]  = irq_timer;
      nxt.mip[11] = irq_ext;

      {nxt.mcycle_hi, nxt.mcycle_lo}     = mcycle_nxt;
      {nxt.minstret_hi, nxt.minstret_lo} = minstret_nxt;

      if (wr)
      begin
         case (sel.reg_sel)
            REG_MSTATUS:
               nxt.mstatus = apply_op(sel.op, state.mstatus, sel.wdata, `CSR_MASK_MSTATUS);
            REG_MIE:
               nxt.mie = apply_op(sel.op, state.mie, sel.wdata, `CSR_MASK_MIE);
            REG_MTVEC:
               nxt.mtvec = apply_op(sel.op, state.mtvec, sel.wdata, `CSR_MASK_MTVEC);
            REG_MCOUNTINHIBIT:
               nxt.mcountinhibit = apply_op(sel.op, state.mcountinhibit, sel.wdata,
                                            `CSR_MASK_MCOUNTINHIBIT);
            REG_MSCRATCH:
               nxt.mscratch = apply_op(sel.op, state.mscratch, sel.wdata, `CSR_MASK_FULL);
            REG_MEPC:
               nxt.mepc = apply_op(sel.op, state.mepc, sel.wdata, `CSR_MASK_FULL);
            REG_MCAUSE:
               nxt.mcause = apply_op(sel.op, state.mcause, sel.wdata, `CSR_MASK_FULL);
            REG_MTVAL:
               nxt.mtval = apply_op(sel.op, state.mtval, sel.wdata, `CSR_MASK_FULL);
            // Written half replaces the increment, other half holds
            REG_MCYCLE:
            begin
               nxt.mcycle_lo = apply_op(sel.op, state.mcycle_lo, sel.wdata, `CSR_MASK_FULL);
               nxt.mcycle_hi = state.mcycle_hi;
            end
            REG_MCYCLEH:
            begin
               nxt.mcycle_hi = apply_op(sel.op, state.mcycle_hi, sel.wdata, `CSR_MASK_FULL);
               nxt.mcycle_lo = state.mcycle_lo;
            end
            REG_MINSTRET:
            begin
               nxt.minstret_lo = apply_op(sel.op, state.minstret_lo, sel.wdata,
                                          `CSR_MASK_FULL);
               nxt.minstret_hi = state.minstret_hi;
            end
            REG_MINSTRETH:
            begin
               nxt.minstret_hi = apply_op(sel.op, state.minstret_hi, sel.wdata,
                                          `CSR_MASK_FULL);
               nxt.minstret_lo = state.minstret_lo;
            end
            default:
               nxt.mip = nxt.mip;
         endcase
      end

      // Trap entry stacks MIE into MPIE
      if (trap.take)
      begin
         nxt.mepc       = trap.epc;
         nxt.mcause     = trap.cause;
         nxt.mtval      = trap.tval;
         nxt.mstatus[7] = state.mstatus[3];
         nxt.mstatus[3] = 1'b0;
      end
      else if (mret)
      begin
         nxt.mstatus[3] = state.mstatus[7];
         nxt.mstatus[7] = 1'b1;
      end
   end

   always_ff @(posedge clk_in)
   begin
      if (rst)
      begin
         state       <= '0;
         state.mtvec <= `CSR_RESET_VECTOR;
      end
      else
      begin
         state <= nxt;
      end
   end

   // ----------------------------------------
   // Trap target and interrupt pending
   // ----------------------------------------
   assign mtvec_base = {state.mtvec[31:2], 2'b00};
   // Vectored mode jumps to base plus four times the interrupt code
   assign vector_off = {state.mcause[29:0], 2'b00};
   assign trap_pc    = (state.mtvec[0] && state.mcause[31]) ? mtvec_base + vector_off
                                                            : mtvec_base;

   assign epc         = state.mepc;
   assign irq_pending = state.mstatus[3] && |(state.mie & state.mip);

endmodule

`default_nettype wire

// ==== csr/csr_decode.sv ====
// CSR address decode into a register select with legality and write enable
`timescale 1ns/10ps
`default_nettype none

`include "csr_config.svh"

module csr_decode
   import csr_pkg::*;
(
   input  csr_req_t req,
   output csr_sel_t sel
);

   csr_reg_e reg_sel;
   logic     read_only;
   logic     would_write;
   logic     writable;
   logic     illegal;

   // ----------------------------------------
   // Address map
   // ----------------------------------------
   always_comb
   begin
      case (req.addr)
         `CSR_ADDR_MSTATUS:       reg_sel = REG_MSTATUS;
         `CSR_ADDR_MISA:          reg_sel = REG_MISA;
         `CSR_ADDR_MIE:           reg_sel = REG_MIE;
         `CSR_ADDR_MTVEC:         reg_sel = REG_MTVEC;
         `CSR_ADDR_MCOUNTINHIBIT: reg_sel = REG_MCOUNTINHIBIT;
         `CSR_ADDR_MSCRATCH:      reg_sel = REG_MSCRATCH;
         `CSR_ADDR_MEPC:          reg_sel = REG_MEPC;
         `CSR_ADDR_MCAUSE:        reg_sel = REG_MCAUSE;
         `CSR_ADDR_MTVAL:         reg_sel = REG_MTVAL;
         `CSR_ADDR_MIP:           reg_sel = REG_MIP;
         `CSR_ADDR_MCYCLE:        reg_sel = REG_MCYCLE;
         `CSR_ADDR_MCYCLEH:       reg_sel = REG_MCYCLEH;
         `CSR_ADDR_MINSTRET:      reg_sel = REG_MINSTRET;
         `CSR_ADDR_MINSTRETH:     reg_sel = REG_MINSTRETH;
         `CSR_ADDR_MVENDORID:     reg_sel = REG_MVENDORID;
         `CSR_ADDR_MARCHID:       reg_sel = REG_MARCHID;
         `CSR_ADDR_MIMPID:        reg_sel = REG_MIMPID;
         `CSR_ADDR_MHARTID:       reg_sel = REG_MHARTID;
         default:                 reg_sel = REG_NONE;
      endcase
   end

   // ----------------------------------------
   // Legality
   // ----------------------------------------
   // Top address bits 11 means read-only space
   assign read_only = &req.addr[11:10];

   // Set and clear with zero data only read
   assign would_write = (req.op == CSR_RW) || (req.wdata != '0);

   // misa is WARL and ignores writes, mip follows the interrupt lines
   assign writable = !read_only &&
                     !(reg_sel inside {REG_NONE, REG_MISA, REG_MIP});

   assign illegal = req.valid &&
                    ((reg_sel == REG_NONE) || (read_only && would_write));

   // Pass data and op through with the decoded select
   assign sel = '{valid:    req.valid,
                  reg_sel:  reg_sel,
                  op:       req.op,
                  wdata:    req.wdata,
                  write_en: req.valid && !illegal && writable && would_write,
                  illegal:  illegal};

endmodule

`default_nettype wire

// ==== common/csr_pkg.sv ====
// Shared types of the machine-mode CSR file: words, enums and bus structs
`default_nettype none

`include "csr_config.svh"

package csr_pkg;

   // Plain vectors with a meaning
   typedef logic [`CSR_XLEN-1:0]   xlen_t;
   typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
   typedef logic [`CSR_XLEN-1:0]   cause_t;
   typedef logic [`CSR_CNT_W-1:0]  counter_t;

   // Access operations, same low bits as the funct3 encoding
   typedef enum logic [1:0] {
      CSR_RW = 2'b01,
      CSR_RS = 2'b10,
      CSR_RC = 2'b11
   } csr_op_e;

   // ----------------------------------------
   // Register select
   // ----------------------------------------
   // Counter halves are separate entries
   typedef enum logic [4:0] {
      REG_NONE,
      REG_MSTATUS,
      REG_MISA,
      REG_MIE,
      REG_MTVEC,
      REG_MCOUNTINHIBIT,
      REG_MSCRATCH,
      REG_MEPC,
      REG_MCAUSE,
      REG_MTVAL,
      REG_MIP,
      REG_MCYCLE,
      REG_MCYCLEH,
      REG_MINSTRET,
      REG_MINSTRETH,
      REG_MVENDORID,
      REG_MARCHID,
      REG_MIMPID,
      REG_MHARTID
   } csr_reg_e;

   // ----------------------------------------
   // Bus structs
   // ----------------------------------------
   // One access, 47 bits
   typedef struct packed {
      logic      valid;
      csr_op_e   op;
      csr_addr_t addr;
      xlen_t     wdata;
   } csr_req_t;

   // Decoded access, 42 bits
   typedef struct packed {
      logic     valid;
      csr_reg_e reg_sel;
      csr_op_e  op;
      xlen_t    wdata;
      logic     write_en;
      logic     illegal;
   } csr_sel_t;

   // Trap entry, 97 bits
   typedef struct packed {
      logic   take;
      cause_t cause;
      xlen_t  epc;
      xlen_t  tval;
   } trap_req_t;

   // Access response, 34 bits
   typedef struct packed {
      logic  valid;
      xlen_t rdata;
      logic  illegal;
   } csr_rsp_t;

   // Every stored register, 13 words
   typedef struct packed {
      xlen_t mstatus;
      xlen_t mie;
      xlen_t mtvec;
      xlen_t mcountinhibit;
      xlen_t mscratch;
      xlen_t mepc;
      xlen_t mcause;
      xlen_t mtval;
      xlen_t mip;
      xlen_t mcycle_lo;
      xlen_t mcycle_hi;
      xlen_t minstret_lo;
      xlen_t minstret_hi;
   } csr_state_t;

endpackage

`default_nettype wire

// ==== common/csr_config.svh ====
// Machine-mode CSR file configuration with addresses, write masks, reset and ID values
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// Widths fixed by RV32
`define CSR_XLEN              32
`define CSR_ADDR_W            12
`define CSR_CNT_W             64

// ----------------------------------------
// Register addresses
// ----------------------------------------
`define CSR_ADDR_MSTATUS      12'h300
`define CSR_ADDR_MISA         12'h301
`define CSR_ADDR_MIE          12'h304
`define CSR_ADDR_MTVEC        12'h305
`define CSR_ADDR_MCOUNTINHIBIT 12'h320
`define CSR_ADDR_MSCRATCH     12'h340
`define CSR_ADDR_MEPC         12'h341
`define CSR_ADDR_MCAUSE       12'h342
`define CSR_ADDR_MTVAL        12'h343
`define CSR_ADDR_MIP          12'h344
`define CSR_ADDR_MCYCLE       12'hB00
`define CSR_ADDR_MINSTRET     12'hB02
`define CSR_ADDR_MCYCLEH      12'hB80
`define CSR_ADDR_MINSTRETH    12'hB82
`define CSR_ADDR_MVENDORID    12'hF11
`define CSR_ADDR_MARCHID      12'hF12
`define CSR_ADDR_MIMPID       12'hF13
`define CSR_ADDR_MHARTID      12'hF14

// ----------------------------------------
// Write masks, a set bit is writable
// ----------------------------------------
// MIE (bit 3) and MPIE (bit 7)
`define CSR_MASK_MSTATUS      32'h0000_0088
// MSIE, MTIE and MEIE
`define CSR_MASK_MIE          32'h0000_0888
// Mode bit 1 stays zero, only direct and vectored modes
`define CSR_MASK_MTVEC        32'hFFFF_FFFD
// CY and IR only, bit 1 has no counter behind it
`define CSR_MASK_MCOUNTINHIBIT 32'h0000_0005
`define CSR_MASK_FULL         32'hFFFF_FFFF

// ----------------------------------------
// Reset and constant values
// ----------------------------------------
`define CSR_RESET_VECTOR      32'h0000_0100
// MXL = 1 (RV32), I extension
`define CSR_MISA_VALUE        32'h4000_0100
`define CSR_MVENDORID_VALUE   32'h0000_0000
`define CSR_MARCHID_VALUE     32'h0000_0000
`define CSR_MIMPID_VALUE      32'h0000_0001
`define CSR_MHARTID_VALUE     32'h0000_0000
// MPP pair 12:11, always machine mode
`define CSR_MSTATUS_MPP       32'h0000_1800

`endif
